//--- Makefile
TOP = tb_sblk

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

.PHONY: all lint sim clean

//--- flist.f
+incdir+.
sblk_pkg.sv
sblk_ctrl.sv
stile.sv
psum_accum.sv
psum_buffer.sv
psum_readout.sv
sblk_top.sv
tb_sblk.sv

//--- psum_accum.sv
// Row accumulator: sums the cascade over k, then a pipelined read-modify-write of each row
`timescale 1ns/1ns
`default_nettype none

module psum_accum (
   input  wire                  clk_h,
   input  wire                  rst_n,
   input  wire sblk_pkg::casc_t casc_in,
   input  wire                  accumulate,
   output logic                 rd_req,
   output sblk_pkg::row_t       rd_row,
   input  wire sblk_pkg::psum_t rd_data,
   output logic                 wr_en,
   output sblk_pkg::row_t       wr_row,
   output sblk_pkg::psum_t      wr_data
);
   import sblk_pkg::*;

   psum_t run_sum;
   psum_t term_sum;
   logic  hold_valid;
   row_t  hold_row;
   psum_t hold_sum;

   // Restart the row sum on the first term
   assign term_sum = (casc_in.first ? '0 : run_sum) + casc_in.sum;

   always_ff @(posedge clk_h) begin : run_reg
      if (casc_in.valid) begin
         run_sum <= term_sum;
      end
   end

   // Old row value only fetched when accumulating
   assign rd_req = casc_in.valid && casc_in.last && accumulate;
   assign rd_row = casc_in.row;

   always_ff @(posedge clk_h or negedge rst_n) begin : hold_ctrl
      if (!rst_n) begin
         hold_valid <= 1'b0;
      end else begin
         hold_valid <= casc_in.valid && casc_in.last;
      end
   end

   // Finished row waits here one cycle for the read data
   always_ff @(posedge clk_h) begin : hold_data
      if (casc_in.valid && casc_in.last) begin
         hold_row <= casc_in.row;
         hold_sum <= term_sum;
      end
   end

   // Next row's read overlaps this write, rows always differ
   assign wr_en   = hold_valid;
   assign wr_row  = hold_row;
   assign wr_data = hold_sum + (accumulate ? rd_data : '0);

endmodule

`default_nettype wire

//--- psum_buffer.sv
// Partial-sum row memory with one write port and one arbitrated read port
`timescale 1ns/1ns
`default_nettype none

module psum_buffer (
   input  wire                  clk_h,
   input  wire                  rst_n,
   input  wire                  wr_en,
   input  wire sblk_pkg::row_t  wr_row,
   input  wire sblk_pkg::psum_t wr_data,
   input  wire                  acc_req,
   input  wire sblk_pkg::row_t  acc_row,
   output sblk_pkg::psum_t      acc_data,
   input  wire                  ro_req,
   input  wire sblk_pkg::row_t  ro_row,
   output logic                 ro_grant,
   output sblk_pkg::psum_t      ro_data
);
   import sblk_pkg::*;

   psum_t mem [PSUM_DEPTH];
   psum_t rd_q;
   row_t  rd_row;
   logic  rd_en;

   // Fixed priority, the accumulator never waits
   assign ro_grant = ro_req && !acc_req;
   assign rd_en    = acc_req || ro_req;
   assign rd_row   = acc_req ? acc_row : ro_row;

   always_ff @(posedge clk_h) begin : mem_write
      if (wr_en) begin
         mem[wr_row] <= wr_data;
      end
   end

   // Data one cycle after the grant, kept until the next read
   always_ff @(posedge clk_h or negedge rst_n) begin : mem_read
      if (!rst_n) begin
         rd_q <= '0;
      end else if (rd_en) begin
         rd_q <= mem[rd_row];
      end
   end

   // Each requester knows when the data is its own
   assign acc_data = rd_q;
   assign ro_data  = rd_q;

endmodule

`default_nettype wire

//--- psum_readout.sv
// Host readout: request holder, read port request, response with back-pressure
`timescale 1ns/1ns
`default_nettype none

module psum_readout (
   input  wire                  clk_h,
   input  wire                  rst_n,
   input  wire sblk_pkg::row_t  rd_addr,
   input  wire                  rd_req_valid,
   output logic                 rd_req_ready,
   output sblk_pkg::psum_t      rd_data,
   output logic                 rd_rsp_valid,
   input  wire                  rd_rsp_ready,
   output logic                 ro_req,
   output sblk_pkg::row_t       ro_row,
   input  wire                  ro_grant,
   input  wire sblk_pkg::psum_t ro_data
);
   import sblk_pkg::*;

   typedef enum logic [1:0] {
      RO_IDLE,
      RO_WAIT,
      RO_CAPT,
      RO_HOLD
   } ro_state_t;

   ro_state_t state;
   row_t      row_q;
   psum_t     data_q;

   always_ff @(posedge clk_h or negedge rst_n) begin : state_reg
      if (!rst_n) begin
         state <= RO_IDLE;
      end else begin
         case (state)
            RO_IDLE: if (rd_req_valid) state <= RO_WAIT;
            // Loses to the accumulator while it is busy
            RO_WAIT: if (ro_grant) state <= RO_CAPT;
            RO_CAPT: state <= rd_rsp_ready ? RO_IDLE : RO_HOLD;
            RO_HOLD: if (rd_rsp_ready) state <= RO_IDLE;
            default: state <= RO_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_h) begin : row_reg
      if (rd_req_valid && rd_req_ready) begin
         row_q <= rd_addr;
      end
   end

   // Buffer data may change later, keep a copy for a stalled response
   always_ff @(posedge clk_h) begin : data_reg
      if (state == RO_CAPT) begin
         data_q <= ro_data;
      end
   end

   // One request in flight
   assign rd_req_ready = (state == RO_IDLE);
   assign ro_req       = (state == RO_WAIT);
   assign ro_row       = row_q;
   assign rd_rsp_valid = (state == RO_CAPT) || (state == RO_HOLD);
   assign rd_data      = (state == RO_CAPT) ? ro_data : data_q;

endmodule

`default_nettype wire

//--- sblk_ctrl.sv
// Superblock controller: instruction intake, activation load sequencing, compute issue, drain
`timescale 1ns/1ns
`default_nettype none

module sblk_ctrl #(
   parameter int N_TILE = 4
) (
   input  wire                  clk_h,
   input  wire                  rst_n,
   input  wire sblk_pkg::inst_t inst,
   input  wire                  inst_valid,
   output logic                 inst_ready,
   input  wire                  act_valid,
   output logic                 act_ready,
   output logic [N_TILE-1:0]    act_wr_en,
   output sblk_pkg::act_addr_t  act_wr_addr,
   input  wire                  wgt_valid,
   output logic                 wgt_ready,
   output sblk_pkg::issue_t     issue,
   output logic                 accumulate,
   output logic                 busy
);
   import sblk_pkg::*;

   // Drain covers the tile chain plus the accumulator write-back
   localparam int DRAIN_LEN = N_TILE + 4;
   localparam int DRAIN_W   = $clog2(DRAIN_LEN);

   ctrl_state_t        state;
   ctrl_state_t        state_nxt;
   inst_t              inst_q;
   tile_idx_t          act_tile;
   act_addr_t          act_addr;
   logic               act_all;
   row_t               row_cnt;
   act_addr_t          k_cnt;
   wgt_addr_t          w_addr;
   logic [DRAIN_W-1:0] drain_cnt;
   logic               inst_fire;
   logic               act_fire;
   logic               act_last;
   logic               k_last;
   logic               row_last;

   assign inst_fire = inst_valid && inst_ready;
   assign act_fire  = act_valid && act_ready;

   // Word j goes to tile j mod N_TILE at address j div N_TILE
   assign act_last = (act_tile == tile_idx_t'(N_TILE - 1)) &&
                     (act_addr == act_addr_t'(inst_q.k_len - 1'b1));
   assign k_last   = (k_cnt == act_addr_t'(inst_q.k_len - 1'b1));
   assign row_last = (row_cnt == row_t'(inst_q.m_rows - 1'b1));

   always_comb begin : next_state
      state_nxt = state;
      case (state)
         IDLE:     if (inst_fire) state_nxt = LOAD_ACT;
         // Wait for any offered weight to land before compute starts
         LOAD_ACT: if ((act_all || (act_fire && act_last)) && !wgt_valid) state_nxt = COMPUTE;
         COMPUTE:  if (k_last && row_last) state_nxt = DRAIN;
         DRAIN:    if (drain_cnt == DRAIN_W'(DRAIN_LEN - 1)) state_nxt = IDLE;
         default:  state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk_h or negedge rst_n) begin : state_reg
      if (!rst_n) begin
         state      <= IDLE;
         inst_ready <= 1'b0;
      end else begin
         state      <= state_nxt;
         inst_ready <= (state_nxt == IDLE);
      end
   end

   always_ff @(posedge clk_h or negedge rst_n) begin : inst_reg
      if (!rst_n) begin
         inst_q <= '0;
      end else if (inst_fire) begin
         inst_q <= inst;
      end
   end

   // Activation load position, restarted by each instruction
   always_ff @(posedge clk_h or negedge rst_n) begin : act_cnt_reg
      if (!rst_n) begin
         act_tile <= '0;
         act_addr <= '0;
         act_all  <= 1'b0;
      end else if (inst_fire) begin
         act_tile <= '0;
         act_addr <= '0;
         act_all  <= 1'b0;
      end else if (act_fire) begin
         if (act_last) begin
            act_all <= 1'b1;
         end
         if (act_tile == tile_idx_t'(N_TILE - 1)) begin
            act_tile <= '0;
            act_addr <= act_addr + 1'b1;
         end else begin
            act_tile <= act_tile + 1'b1;
         end
      end
   end

   // Row-major schedule, k fastest, weight address m*k_len+k
   always_ff @(posedge clk_h or negedge rst_n) begin : issue_cnt_reg
      if (!rst_n) begin
         row_cnt <= '0;
         k_cnt   <= '0;
         w_addr  <= '0;
      end else if (state != COMPUTE) begin
         row_cnt <= '0;
         k_cnt   <= '0;
         w_addr  <= '0;
      end else begin
         w_addr <= w_addr + 1'b1;
         if (k_last) begin
            k_cnt   <= '0;
            row_cnt <= row_cnt + 1'b1;
         end else begin
            k_cnt <= k_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_h or negedge rst_n) begin : drain_reg
      if (!rst_n) begin
         drain_cnt <= '0;
      end else if (state == DRAIN) begin
         drain_cnt <= drain_cnt + 1'b1;
      end else begin
         drain_cnt <= '0;
      end
   end

   always_comb begin : act_decode
      for (int i = 0; i < N_TILE; i++) begin
         act_wr_en[i] = act_fire && (act_tile == tile_idx_t'(i));
      end
   end

   // One issue per cycle in COMPUTE, never stalled
   always_comb begin : issue_build
      issue.valid    = (state == COMPUTE);
      issue.first    = (k_cnt == '0);
      issue.last     = k_last;
      issue.row      = row_cnt;
      issue.act_addr = k_cnt;
      issue.wgt_addr = w_addr;
   end

   assign act_ready   = (state == LOAD_ACT) && !act_all;
   assign act_wr_addr = act_addr;
   // Weight port closed while the tiles read their buffers
   assign wgt_ready   = (state == IDLE) || (state == LOAD_ACT);
   assign accumulate  = inst_q.accumulate;
   assign busy        = (state != IDLE);

endmodule

`default_nettype wire

//--- sblk_pkg.sv
// Superblock widths, data typedefs, instruction and transfer structs, controller states
`default_nettype none

package sblk_pkg;

   // Data widths
   localparam int ACT_W  = 16;
   localparam int WGT_W  = 16;
   localparam int PSUM_W = 32;

   typedef logic signed [ACT_W-1:0] act_t;
   typedef logic signed [WGT_W-1:0] wgt_t;
   // Partial sums wrap on overflow
   typedef logic [PSUM_W-1:0] psum_t;

   // Buffer depths per tile and for the shared row buffer
   localparam int K_MAX      = 16;
   localparam int W_DEPTH    = 256;
   localparam int PSUM_DEPTH = 64;

   typedef logic [$clog2(K_MAX)-1:0]      act_addr_t;
   typedef logic [$clog2(W_DEPTH)-1:0]    wgt_addr_t;
   typedef logic [$clog2(PSUM_DEPTH)-1:0] row_t;

   // Tile select in a weight write, room for eight tiles
   localparam int TILE_W = 3;
   typedef logic [TILE_W-1:0] tile_idx_t;

   // One extra bit so the full count fits
   typedef logic [$clog2(K_MAX):0]      klen_t;
   typedef logic [$clog2(PSUM_DEPTH):0] mrows_t;

   // m_rows * k_len stays within W_DEPTH
   typedef struct packed {
      klen_t  k_len;
      mrows_t m_rows;
      logic   accumulate;
   } inst_t;

   typedef struct packed {
      tile_idx_t tile;
      wgt_addr_t addr;
      wgt_t      data;
   } wgt_wr_t;

   // One scheduled multiply step
   typedef struct packed {
      logic      valid;
      logic      first;
      logic      last;
      row_t      row;
      act_addr_t act_addr;
      wgt_addr_t wgt_addr;
   } issue_t;

   // Cascade word passed from tile to tile
   typedef struct packed {
      logic  valid;
      logic  first;
      logic  last;
      row_t  row;
      psum_t sum;
   } casc_t;

   typedef enum logic [1:0] {
      IDLE,
      LOAD_ACT,
      COMPUTE,
      DRAIN
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- sblk_top.sv
// Superblock top: controller, tile cascade chain, row accumulator, row buffer and readout
`timescale 1ns/1ns
`default_nettype none

module sblk_top #(
   parameter int N_TILE = 4
) (
   input  wire                    clk_h,
   input  wire                    rst_n,
   input  wire sblk_pkg::inst_t   inst,
   input  wire                    inst_valid,
   output logic                   inst_ready,
   input  wire sblk_pkg::act_t    act_in,
   input  wire                    act_valid,
   output logic                   act_ready,
   input  wire sblk_pkg::wgt_wr_t wgt_in,
   input  wire                    wgt_valid,
   output logic                   wgt_ready,
   input  wire sblk_pkg::row_t    rd_addr,
   input  wire                    rd_req_valid,
   output logic                   rd_req_ready,
   output sblk_pkg::psum_t        rd_data,
   output logic                   rd_rsp_valid,
   input  wire                    rd_rsp_ready,
   output logic                   busy
);
   import sblk_pkg::*;

   logic [N_TILE-1:0] act_wr_en;
   act_addr_t         act_wr_addr;
   logic              accumulate;
   // Element i feeds tile i, element i+1 comes out of it
   issue_t            issue_w [N_TILE+1];
   casc_t             casc_w [N_TILE+1];
   logic              acc_req;
   row_t              acc_row;
   psum_t             acc_data;
   logic              wr_en;
   row_t              wr_row;
   psum_t             wr_data;
   logic              ro_req;
   row_t              ro_row;
   logic              ro_grant;
   psum_t             ro_data;

   // Head of the cascade adds nothing
   assign casc_w[0] = '0;

   sblk_ctrl #(
      .N_TILE (N_TILE)
   ) u_ctrl (
      .clk_h       (clk_h),
      .rst_n       (rst_n),
      .inst        (inst),
      .inst_valid  (inst_valid),
      .inst_ready  (inst_ready),
      .act_valid   (act_valid),
      .act_ready   (act_ready),
      .act_wr_en   (act_wr_en),
      .act_wr_addr (act_wr_addr),
      .wgt_valid   (wgt_valid),
      .wgt_ready   (wgt_ready),
      .issue       (issue_w[0]),
      .accumulate  (accumulate),
      .busy        (busy)
   );

   for (genvar i = 0; i < N_TILE; i++) begin : g_tile
      stile #(
         .TILE_IDX (i)
      ) u_tile (
         .clk_h       (clk_h),
         .rst_n       (rst_n),
         .act_in      (act_in),
         .act_wr_en   (act_wr_en[i]),
         .act_wr_addr (act_wr_addr),
         .wgt_in      (wgt_in),
         .wgt_wr_en   (wgt_valid && wgt_ready),
         .issue_in    (issue_w[i]),
         .issue_out   (issue_w[i+1]),
         .casc_in     (casc_w[i]),
         .casc_out    (casc_w[i+1])
      );
   end

   psum_accum u_accum (
      .clk_h      (clk_h),
      .rst_n      (rst_n),
      .casc_in    (casc_w[N_TILE]),
      .accumulate (accumulate),
      .rd_req     (acc_req),
      .rd_row     (acc_row),
      .rd_data    (acc_data),
      .wr_en      (wr_en),
      .wr_row     (wr_row),
      .wr_data    (wr_data)
   );

   psum_buffer u_buffer (
      .clk_h    (clk_h),
      .rst_n    (rst_n),
      .wr_en    (wr_en),
      .wr_row   (wr_row),
      .wr_data  (wr_data),
      .acc_req  (acc_req),
      .acc_row  (acc_row),
      .acc_data (acc_data),
      .ro_req   (ro_req),
      .ro_row   (ro_row),
      .ro_grant (ro_grant),
      .ro_data  (ro_data)
   );

   psum_readout u_readout (
      .clk_h        (clk_h),
      .rst_n        (rst_n),
      .rd_addr      (rd_addr),
      .rd_req_valid (rd_req_valid),
      .rd_req_ready (rd_req_ready),
      .rd_data      (rd_data),
      .rd_rsp_valid (rd_rsp_valid),
      .rd_rsp_ready (rd_rsp_ready),
      .ro_req       (ro_req),
      .ro_row       (ro_row),
      .ro_grant     (ro_grant),
      .ro_data      (ro_data)
   );

endmodule

`default_nettype wire

//--- stile.sv
// Compute tile: activation and weight buffers, multiply-add cascade stage, issue skew register
`timescale 1ns/1ns
`default_nettype none

module stile #(
   parameter int TILE_IDX = 0
) (
   input  wire                    clk_h,
   input  wire                    rst_n,
   input  wire sblk_pkg::act_t    act_in,
   input  wire                    act_wr_en,
   input  wire sblk_pkg::act_addr_t act_wr_addr,
   input  wire sblk_pkg::wgt_wr_t wgt_in,
   input  wire                    wgt_wr_en,
   input  wire sblk_pkg::issue_t  issue_in,
   output sblk_pkg::issue_t       issue_out,
   input  wire sblk_pkg::casc_t   casc_in,
   output sblk_pkg::casc_t        casc_out
);
   import sblk_pkg::*;

   localparam tile_idx_t MY_IDX = tile_idx_t'(TILE_IDX);

   act_t act_mem [K_MAX];
   wgt_t wgt_mem [W_DEPTH];
   act_t act_q;
   wgt_t wgt_q;
   logic signed [ACT_W+WGT_W-1:0] prod;

   // Activation slice written by the controller
   always_ff @(posedge clk_h) begin : act_write
      if (act_wr_en) begin
         act_mem[act_wr_addr] <= act_in;
      end
   end

   // Weights broadcast to all tiles, only the addressed tile keeps them
   always_ff @(posedge clk_h) begin : wgt_write
      if (wgt_wr_en && (wgt_in.tile == MY_IDX)) begin
         wgt_mem[wgt_in.addr] <= wgt_in.data;
      end
   end

   // Registered reads, data ready the cycle after the issue
   always_ff @(posedge clk_h) begin : buf_read
      if (issue_in.valid) begin
         act_q <= act_mem[issue_in.act_addr];
         wgt_q <= wgt_mem[issue_in.wgt_addr];
      end
   end

   // Skew register, also holds the step while the buffers are read
   always_ff @(posedge clk_h or negedge rst_n) begin : issue_reg
      if (!rst_n) begin
         issue_out <= '0;
      end else begin
         issue_out <= issue_in;
      end
   end

   // Full-width signed product, exactly PSUM_W bits
   assign prod = act_q * wgt_q;

   // casc_in from the previous tile lines up with this tile's product
   always_ff @(posedge clk_h or negedge rst_n) begin : casc_reg
      if (!rst_n) begin
         casc_out <= '0;
      end else begin
         casc_out.valid <= issue_out.valid;
         casc_out.first <= issue_out.first;
         casc_out.last  <= issue_out.last;
         casc_out.row   <= issue_out.row;
         casc_out.sum   <= psum_t'(prod) + casc_in.sum;
      end
   end

endmodule

`default_nettype wire

//--- tb_sblk_tasks.svh
// Directed superblock tests with their handshake, load, readout and check helpers
`ifndef TB_SBLK_TASKS_SVH
`define TB_SBLK_TASKS_SVH

// Handshake channels
localparam int CH_INST = 0;
localparam int CH_ACT  = 1;
localparam int CH_WGT  = 2;
localparam int CH_RD   = 3;

task automatic check_val(input string name, input int row, input psum_t exp, input psum_t act);
   assert (act == exp)
   else begin
      $display("FAIL %s row %0d: expected %08h, actual %08h", name, row, exp, act);
      err_cnt++;
   end
endtask

task automatic check_cond(input string name, input bit ok, input string what);
   assert (ok)
   else begin
      $display("ERROR %s: %s", name, what);
      err_cnt++;
   end
endtask

task automatic end_test(input string name, input int errs_before);
   test_cnt++;
   if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
   end else begin
      $display("test %s: %0d failed checks", name, err_cnt - errs_before);
      fail_cnt++;
   end
endtask

function automatic logic chan_ready(input int ch);
   case (ch)
      CH_INST: return inst_ready;
      CH_ACT:  return act_ready;
      CH_WGT:  return wgt_ready;
      default: return rd_req_ready;
   endcase
endfunction

// Ready is sampled mid-cycle and the transfer follows on the next edge
task automatic wait_accept(input string name, input int ch);
   logic ok;
   do begin
      @(negedge clk_h);
      ok = chan_ready(ch);
      if (ch == CH_ACT) begin
         check_cond(name, !inst_ready, "inst_ready high during activation load");
      end
      @(posedge clk_h);
      #1;
   end while (!ok);
endtask

task automatic load_weights(input string name, input int k_len, input int m_rows);
   for (int t = 0; t < N_TILE; t++) begin
      for (int a = 0; a < k_len * m_rows; a++) begin
         wgt_m[t][a] = wgt_t'(rand_bits(WGT_W));
         wgt_in.tile = tile_idx_t'(t);
         wgt_in.addr = wgt_addr_t'(a);
         wgt_in.data = wgt_m[t][a];
         wgt_valid   = 1'b1;
         wait_accept(name, CH_WGT);
      end
   end
   wgt_valid = 1'b0;
endtask

// Word j lands in tile j mod N_TILE at address j div N_TILE
task automatic load_acts(input string name, input int k_len, input bit gaps);
   act_t v;
   int   idle;
   for (int j = 0; j < N_TILE * k_len; j++) begin
      v = act_t'(rand_bits(ACT_W));
      act_m[j % N_TILE][j / N_TILE] = v;
      idle = gaps ? int'(rand_bits(2)) : 0;
      repeat (idle) begin
         @(posedge clk_h);
         #1;
      end
      act_in    = v;
      act_valid = 1'b1;
      wait_accept(name, CH_ACT);
      act_valid = 1'b0;
   end
endtask

// No port may accept input during compute and drain
task automatic wait_done(input string name);
   @(negedge clk_h);
   while (busy) begin
      check_cond(name, !inst_ready && !act_ready && !wgt_ready, "a ready was high while busy");
      @(negedge clk_h);
   end
   @(posedge clk_h);
   #1;
endtask

task automatic run_inst(input string name, input int k_len, input int m_rows,
                        input bit acc, input bit gaps);
   inst.k_len      = klen_t'(k_len);
   inst.m_rows     = mrows_t'(m_rows);
   inst.accumulate = acc;
   inst_valid      = 1'b1;
   wait_accept(name, CH_INST);
   inst_valid = 1'b0;
   load_acts(name, k_len, gaps);
   wait_done(name);
   model_run(k_len, m_rows, acc);
endtask

task automatic read_row(input string name, input row_t row, input bit bp, output psum_t data);
   int stall;
   rd_addr      = row;
   rd_req_valid = 1'b1;
   wait_accept(name, CH_RD);
   rd_req_valid = 1'b0;
   @(negedge clk_h);
   while (!rd_rsp_valid) begin
      check_cond(name, !rd_req_ready, "rd_req_ready high while a read was pending");
      @(negedge clk_h);
   end
   data  = rd_data;
   stall = bp ? int'(rand_bits(2)) : 0;
   // Response held and no new request taken while stalled
   repeat (stall) begin
      @(posedge clk_h);
      #1;
      @(negedge clk_h);
      check_cond(name, rd_rsp_valid && !rd_req_ready,
                 "response dropped or a new request was taken while stalled");
      check_val(name, int'(row), data, rd_data);
   end
   @(posedge clk_h);
   #1;
   rd_rsp_ready = 1'b1;
   @(posedge clk_h);
   #1;
   rd_rsp_ready = 1'b0;
endtask

// Every known row is read so untouched rows are checked too
task automatic check_rows(input string name, input bit bp);
   psum_t got;
   for (int r = 0; r < PSUM_DEPTH; r++) begin
      if (known[r]) begin
         read_row(name, row_t'(r), bp, got);
         check_val(name, r, exp_m[r], got);
      end
   end
endtask

task automatic test_reset();
   int e0;
   e0 = err_cnt;
   @(posedge clk_h);
   #1;
   @(negedge clk_h);
   check_cond("reset", !busy && !act_ready && !rd_rsp_valid, "an output is high after reset");
   check_cond("reset", inst_ready && wgt_ready && rd_req_ready, "a ready is low after reset");
   @(posedge clk_h);
   #1;
   end_test("reset", e0);
endtask

task automatic test_overwrite();
   int e0;
   e0 = err_cnt;
   load_weights("overwrite", 3, 5);
   run_inst("overwrite", 3, 5, 1'b0, 1'b0);
   check_rows("overwrite", 1'b0);
   end_test("overwrite", e0);
endtask

// Reuses the weights with new activations and fewer rows
task automatic test_accumulate();
   int e0;
   e0 = err_cnt;
   run_inst("accumulate", 3, 3, 1'b1, 1'b0);
   check_rows("accumulate", 1'b0);
   end_test("accumulate", e0);
endtask

task automatic test_load_backpressure();
   int e0;
   e0 = err_cnt;
   load_weights("load_bp", 4, 6);
   run_inst("load_bp", 4, 6, 1'b0, 1'b1);
   check_rows("load_bp", 1'b0);
   end_test("load_bp", e0);
endtask

task automatic test_read_backpressure();
   int e0;
   e0 = err_cnt;
   load_weights("read_bp", 2, 8);
   run_inst("read_bp", 2, 8, 1'b0, 1'b0);
   check_rows("read_bp", 1'b1);
   end_test("read_bp", e0);
endtask

// Shortest k with every row and then the longest k
task automatic test_edge_sizes();
   int e0;
   e0 = err_cnt;
   load_weights("edge_sizes", 1, 64);
   run_inst("edge_sizes", 1, 64, 1'b0, 1'b0);
   check_rows("edge_sizes", 1'b0);
   load_weights("edge_sizes", 16, 16);
   run_inst("edge_sizes", 16, 16, 1'b0, 1'b1);
   check_rows("edge_sizes", 1'b1);
   end_test("edge_sizes", e0);
endtask

`endif

//--- tb_sblk.sv
// Superblock testbench top: clock, reset, DUT, watchdog, LFSR, reference model, test sequence
`timescale 1ns/1ns
`default_nettype none

module tb_sblk;
   import sblk_pkg::*;

   localparam int N_TILE = 4;
   localparam int CLK_NS = 8;
   // Headroom over the estimated run length
   localparam int MARGIN = 2;

   logic    clk_h;
   logic    rst_n;
   inst_t   inst;
   logic    inst_valid;
   logic    inst_ready;
   act_t    act_in;
   logic    act_valid;
   logic    act_ready;
   wgt_wr_t wgt_in;
   logic    wgt_valid;
   logic    wgt_ready;
   row_t    rd_addr;
   logic    rd_req_valid;
   logic    rd_req_ready;
   psum_t   rd_data;
   logic    rd_rsp_valid;
   logic    rd_rsp_ready;
   logic    busy;

   // Reference model: weights and activations per tile, expected rows
   wgt_t  wgt_m [N_TILE][W_DEPTH];
   act_t  act_m [N_TILE][K_MAX];
   psum_t exp_m [PSUM_DEPTH];
   // Rows that hold a known value
   bit    known [PSUM_DEPTH];

   logic [15:0] lfsr_q;
   int          err_cnt;
   int          test_cnt;
   int          fail_cnt;

   sblk_top #(
      .N_TILE (N_TILE)
   ) DUT (
      .clk_h        (clk_h),
      .rst_n        (rst_n),
      .inst         (inst),
      .inst_valid   (inst_valid),
      .inst_ready   (inst_ready),
      .act_in       (act_in),
      .act_valid    (act_valid),
      .act_ready    (act_ready),
      .wgt_in       (wgt_in),
      .wgt_valid    (wgt_valid),
      .wgt_ready    (wgt_ready),
      .rd_addr      (rd_addr),
      .rd_req_valid (rd_req_valid),
      .rd_req_ready (rd_req_ready),
      .rd_data      (rd_data),
      .rd_rsp_valid (rd_rsp_valid),
      .rd_rsp_ready (rd_rsp_ready),
      .busy         (busy)
   );

   initial clk_h = 1'b0;
   always #(CLK_NS / 2) clk_h = ~clk_h;

   // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int b = 0; b < n; b++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // y[m] = old y[m] when accumulating, plus the sum over tiles and k of W*A
   task automatic model_run(input int k_len, input int m_rows, input bit acc);
      psum_t sum;
      for (int m = 0; m < m_rows; m++) begin
         sum = acc ? exp_m[m] : '0;
         for (int t = 0; t < N_TILE; t++) begin
            for (int k = 0; k < k_len; k++) begin
               // 16x16 signed product fits in 32 bits, the sum wraps
               sum = sum + psum_t'(int'(wgt_m[t][m * k_len + k]) * int'(act_m[t][k]));
            end
         end
         exp_m[m] = sum;
         known[m] = 1'b1;
      end
   endtask

   // Weights, loads with gaps, compute, drain and stalled reads of all rows
   function automatic int inst_cycles(input int k, input int m);
      return N_TILE * m * k + 4 * N_TILE * k + m * k + N_TILE + 4 + PSUM_DEPTH * 12;
   endfunction

   `include "tb_sblk_tasks.svh"

   initial begin : watchdog
      int limit;
      limit = inst_cycles(3, 5) + inst_cycles(3, 3) + inst_cycles(4, 6) +
              inst_cycles(2, 8) + inst_cycles(1, 64) + inst_cycles(16, 16);
      #(limit * CLK_NS * MARGIN);
      $display("ERROR: watchdog expired, the DUT stopped responding");
      $display("Simulation FAILED");
      $finish;
   end

   initial begin : main
      lfsr_q       = 16'd3;
      err_cnt      = 0;
      test_cnt     = 0;
      fail_cnt     = 0;
      rst_n        = 1'b0;
      inst         = '0;
      inst_valid   = 1'b0;
      act_in       = '0;
      act_valid    = 1'b0;
      wgt_in       = '0;
      wgt_valid    = 1'b0;
      rd_addr      = '0;
      rd_req_valid = 1'b0;
      rd_rsp_ready = 1'b0;
      repeat (2) @(posedge clk_h);
      #1;
      rst_n = 1'b1;

      test_reset();
      test_overwrite();
      test_accumulate();
      test_load_backpressure();
      test_read_backpressure();
      test_edge_sizes();

      $display("tests run %0d, tests failed %0d, checks failed %0d",
               test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
